//--- Makefile
# Verilator build and run of the flow router testbench
# Any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= flow_router_tb
FILELIST  ?= flow_router.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit status does not
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flow_router.f
hdl/flow_pkg.sv
hdl/wb_regs_pkg.sv
hdl/flow_select_regs.sv
hdl/flow_mux_select_unstable.sv
hdl/flow_skid_slice.sv
hdl/flow_router_top.sv
verif/flow_router_tb.sv

//--- hdl/flow_mux_select_unstable.sv
/*
  Combinational flow mux steered by a binary select, zero latency.
  Output valid/data may change while stalled if select moves, so a
  registered stage must follow. clk and rst_n feed the checks only.
*/

`timescale 1ns/10ps

module flow_mux_select_unstable (
  input  logic                 clk,
  input  logic                 rst_n,
  input  flow_pkg::flow_sel_t  select,
  input  flow_pkg::flow_vec_t  push_valid,
  input  flow_pkg::flow_data_t push_data [flow_pkg::NUM_FLOWS],
  output flow_pkg::flow_vec_t  push_ready,
  output logic                 mux_valid,
  output flow_pkg::flow_data_t mux_data,
  input  logic                 mux_ready
);

  import flow_pkg::*;

  // --------------------------------------------------------------------------
  // Steering
  // --------------------------------------------------------------------------

  // Ready goes back to the selected lane only
  assign push_ready = flow_vec_t'(mux_ready) << select;

  // Selected lane straight through
  assign mux_valid = push_valid[select];
  assign mux_data  = push_data[select];

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Never more than one lane handshaking at a time
  ready_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(push_ready));

  // A stalled lane holds valid, so a drop under stall means select moved
  valid_drop_needs_select_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!mux_ready && !$past(mux_ready) && $past(mux_valid) && !mux_valid)
      |-> (select != $past(select)));

endmodule

//--- hdl/flow_pkg.sv
/*
  Streaming path constants and vector types for the flow router.
  Sizes are fixed here and nowhere else. The select width must cover
  NUM_FLOWS exactly, so every select value names a real lane.
*/

package flow_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------

  // Number of push lanes feeding the router
  localparam int NUM_FLOWS = 4;

  // Width of one data beat
  localparam int DATA_W = 16;

  // Binary select width, log2 of NUM_FLOWS
  localparam int SEL_W = 2;

  // Per-flow accepted beat counter width, wraps on overflow
  localparam int CNT_W = 16;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------

  // One beat of payload
  typedef logic [DATA_W-1:0] flow_data_t;

  // Index of a flow
  typedef logic [SEL_W-1:0] flow_sel_t;

  // One bit per flow, bit n belongs to lane n
  typedef logic [NUM_FLOWS-1:0] flow_vec_t;

  // One beat counter
  typedef logic [CNT_W-1:0] beat_cnt_t;

endpackage

//--- hdl/flow_router_top.sv
/*
  Flow router top, Wishbone decode, mux execute, skid result stage.
  Pop side is stable under back-pressure; push lanes see ready only
  when selected. Select writes steer traffic from the next cycle on.
*/

`timescale 1ns/10ps

module flow_router_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // Wishbone classic control port
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  wb_regs_pkg::wb_addr_t wb_adr,
  input  wb_regs_pkg::wb_data_t wb_dat_w,
  output wb_regs_pkg::wb_data_t wb_dat_r,
  output logic                  wb_ack,
  // Push lanes
  input  flow_pkg::flow_vec_t   push_valid,
  output flow_pkg::flow_vec_t   push_ready,
  input  flow_pkg::flow_data_t  push_data [flow_pkg::NUM_FLOWS],
  // Pop stream
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output flow_pkg::flow_data_t  pop_data
);

  import flow_pkg::*;

  // Decode to execute
  flow_sel_t  select;

  // Execute to result
  logic       mux_valid;
  logic       mux_ready;
  flow_data_t mux_data;

  // --------------------------------------------------------------------------
  // Stages
  // --------------------------------------------------------------------------

  // Select register and beat counters
  flow_select_regs u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .select     (select),
    .push_valid (push_valid),
    .push_ready (push_ready)
  );

  // Lane steering
  flow_mux_select_unstable u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .select     (select),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .mux_valid  (mux_valid),
    .mux_data   (mux_data),
    .mux_ready  (mux_ready)
  );

  // Stabilizing buffer
  flow_skid_slice u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (mux_valid),
    .in_data   (mux_data),
    .in_ready  (mux_ready),
    .out_valid (pop_valid),
    .out_data  (pop_data),
    .out_ready (pop_ready)
  );

endmodule

//--- hdl/flow_select_regs.sv
/*
  Wishbone classic slave holding the flow select and per-flow counters.
  Ack is registered and lasts one cycle; the master must hold cyc/stb
  until ack. No error or retry response, no bursts, counters never clear.
*/

`timescale 1ns/10ps

module flow_select_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  wb_regs_pkg::wb_addr_t  wb_adr,
  input  wb_regs_pkg::wb_data_t  wb_dat_w,
  output wb_regs_pkg::wb_data_t  wb_dat_r,
  output logic                   wb_ack,
  output flow_pkg::flow_sel_t    select,
  input  flow_pkg::flow_vec_t    push_valid,
  input  flow_pkg::flow_vec_t    push_ready
);

  import flow_pkg::*;
  import wb_regs_pkg::*;

  // New access, masked during ack so a held strobe is served once
  logic       wb_req;
  logic       cnt_hit;
  flow_sel_t  cnt_idx;
  wb_data_t   rd_word;
  flow_vec_t  beat_acc;
  beat_cnt_t  beat_cnt [NUM_FLOWS];

  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  // --------------------------------------------------------------------------
  // Address decode and read mux
  // --------------------------------------------------------------------------

  // Counter window covers one word per flow
  assign cnt_hit = (wb_adr >= REG_COUNT_BASE) &&
                   (wb_adr < (REG_COUNT_BASE + wb_addr_t'(NUM_FLOWS)));
  assign cnt_idx = flow_sel_t'(wb_adr - REG_COUNT_BASE);

  always_comb begin
    rd_word = '0;
    if (wb_adr == REG_SELECT) begin
      // Upper bits read as zero
      rd_word = wb_data_t'(select);
    end else if (cnt_hit) begin
      rd_word = wb_data_t'(beat_cnt[cnt_idx]);
    end
  end

  // Ack one cycle after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

  // Read word captured with the ack, valid while ack is high
  always_ff @(posedge clk) begin
    if (wb_req) begin
      wb_dat_r <= rd_word;
    end
  end

  // Select write lands on the edge that raises ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      select <= '0;
    end else if (wb_req && wb_we && (wb_adr == REG_SELECT)) begin
      select <= wb_dat_w[SEL_W-1:0];
    end
  end

  // --------------------------------------------------------------------------
  // Beat counters
  // --------------------------------------------------------------------------

  assign beat_acc = push_valid & push_ready;

  // One wrapping counter per lane, bus writes never reach them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_FLOWS; i++) begin
        beat_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_FLOWS; i++) begin
        if (beat_acc[i]) begin
          beat_cnt[i] <= beat_cnt[i] + 1'b1;
        end
      end
    end
  end

  // Single-cycle ack, and only in answer to a strobe
  ack_one_cycle_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack);
  ack_follows_strobe_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

//--- hdl/flow_skid_slice.sv
/*
  Two-entry skid buffer, output register plus one skid register.
  Upstream ready is registered, full rate when both sides are ready.
  Output is stable while stalled. Data registers carry no reset.
*/

`timescale 1ns/10ps

module flow_skid_slice (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  flow_pkg::flow_data_t in_data,
  output logic                 in_ready,
  output logic                 out_valid,
  output flow_pkg::flow_data_t out_data,
  input  logic                 out_ready
);

  import flow_pkg::*;

  // Entries held
  typedef enum logic [1:0] {EMPTY, ONE, TWO} occ_t;

  occ_t       state_q;
  occ_t       state_d;
  logic       in_fire;
  logic       out_fire;
  flow_data_t skid_data;

  assign in_fire   = in_valid && in_ready;
  assign out_fire  = out_valid && out_ready;
  assign out_valid = (state_q != EMPTY);

  // Occupancy next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      EMPTY: if (in_fire) state_d = ONE;
      ONE: begin
        if (in_fire && !out_fire) state_d = TWO;
        else if (!in_fire && out_fire) state_d = EMPTY;
      end
      TWO: if (out_fire) state_d = ONE;
      default: state_d = EMPTY;
    endcase
  end

  // Ready low out of reset, then tracks room for another beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= EMPTY;
      in_ready <= 1'b0;
    end else begin
      state_q  <= state_d;
      in_ready <= (state_d != TWO);
    end
  end

  // Output reg loads when empty or draining, skid takes overflow
  always_ff @(posedge clk) begin
    if (in_fire && (state_q == EMPTY || out_fire)) begin
      out_data <= in_data;
    end else if (out_fire && state_q == TWO) begin
      out_data <= skid_data;
    end
    if (in_fire && state_q == ONE && !out_fire) begin
      skid_data <= in_data;
    end
  end

  // Stable output under back-pressure
  out_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

//--- hdl/wb_regs_pkg.sv
/*
  Wishbone classic control port widths and register map.
  Addresses are word addresses. Counters sit at REG_COUNT_BASE + n,
  one per flow, and are read only. Unmapped addresses read zero.
*/

package wb_regs_pkg;

  // Word address width of the control port
  localparam int WB_ADDR_W = 4;

  // Bus data width
  localparam int WB_DATA_W = 32;

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [WB_DATA_W-1:0] wb_data_t;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------

  // Flow select, read/write, low SEL_W bits only
  localparam wb_addr_t REG_SELECT = wb_addr_t'(0);

  // First beat counter, flow n lives at this address plus n
  localparam wb_addr_t REG_COUNT_BASE = wb_addr_t'(1);

endpackage

//--- verif/flow_router_tb.sv
/*
  Self-checking testbench for the flow router.
  Model and compare processes sample on the falling edge where all
  signals have settled. Random stimulus runs from a fixed seed.
*/

`timescale 1ns/10ps

module flow_router_tb;

  import flow_pkg::*;
  import wb_regs_pkg::*;

  localparam int SEED         = 47;
  localparam int ACK_TIMEOUT  = 20;
  localparam int WAIT_TIMEOUT = 4000;
  localparam int RUN_LIMIT    = 40000;

  logic       clk;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;
  flow_vec_t  push_valid;
  flow_vec_t  push_ready;
  flow_data_t push_data [NUM_FLOWS];
  logic       pop_valid;
  logic       pop_ready;
  flow_data_t pop_data;

  // Model of select, per-lane counts and the expected pop stream
  flow_sel_t  model_sel;
  beat_cnt_t  model_count [NUM_FLOWS];
  flow_data_t exp_q [$];
  int         model_lane;
  // Pop side state from the previous falling edge
  logic       held_valid;
  flow_data_t held_data;
  // Stimulus control and bookkeeping
  logic       pop_hold;
  int         pop_pct;
  flow_vec_t  src_busy;
  int         beats_checked;
  int         err_count;
  int         test_errs;
  int         tests_run;
  int         tests_failed;

  flow_router_top UUT (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .push_valid(push_valid), .push_ready(push_ready), .push_data(push_data),
    .pop_valid(pop_valid), .pop_ready(pop_ready), .pop_data(pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Reference model and compare
  // ------------------------------------------------------------------------

  // Lane whose beat enters the pop stream at the coming edge or -1 when none
  function automatic int routed_lane(flow_vec_t valid, flow_vec_t ready, flow_sel_t sel);
    if (valid[sel] && ready[sel]) begin
      return int'(sel);
    end
    return -1;
  endfunction

  always @(negedge clk) begin
    if (!rst_n) begin
      model_sel = '0;
      for (int i = 0; i < NUM_FLOWS; i++) model_count[i] = '0;
    end else begin
      // Ready on any other lane is a routing fault
      if ((push_ready & ~(flow_vec_t'(1) << model_sel)) != '0) begin
        $display("[ERROR] %0t push_ready: expected no bit outside lane %0d, got %b",
                 $time, model_sel, push_ready);
        err_count++;
      end
      model_lane = routed_lane(push_valid, push_ready, model_sel);
      if (model_lane >= 0) begin
        exp_q.push_back(push_data[model_lane]);
        model_count[model_lane]++;
      end
      // Select write lands on the edge after the strobe
      if (wb_cyc && wb_stb && wb_we && wb_adr == REG_SELECT)
        model_sel = wb_dat_w[SEL_W-1:0];
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      // Nothing may move after a stall across the last edge
      if (held_valid) begin
        check_flag("pop_valid", 1'b1, pop_valid);
        check_data("pop_data", held_data, pop_data);
      end
      if (pop_valid && pop_ready) begin
        if (exp_q.size() == 0) begin
          $display("Beat %h popped at %0t with no beat expected", pop_data, $time);
          err_count++;
        end else begin
          check_data("pop_data", exp_q.pop_front(), pop_data);
          beats_checked++;
        end
      end
      held_valid = pop_valid && !pop_ready;
      held_data  = pop_data;
    end
  end

  // Random pop_ready that is forced low during a hold
  always @(posedge clk) begin
    if (!rst_n || pop_hold) pop_ready <= 1'b0;
    else pop_ready <= (($urandom % 100) < pop_pct);
  end

  // ------------------------------------------------------------------------
  // Compare tasks and bookkeeping
  // ------------------------------------------------------------------------

  task automatic check_data(input string name, input flow_data_t exp, input flow_data_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input beat_cnt_t exp, input beat_cnt_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count != test_errs) tests_failed++;
    $display("test %-24s %s (%0d errors)", name,
             (err_count == test_errs) ? "pass" : "fail", err_count - test_errs);
    test_errs = err_count;
  endtask

  // ------------------------------------------------------------------------
  // Wishbone master and push sources
  // ------------------------------------------------------------------------

  // Ack must show up in the second settled cycle after the strobe
  task automatic wb_access(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                           output wb_data_t rdata);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= addr;
    wb_dat_w <= wdata;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < ACK_TIMEOUT);
    if (!wb_ack) begin
      $display("Timeout: no ack for the access to address %0d", addr);
      err_count++;
    end else if (waited != 2) begin
      $display("Ack for address %0d came %0d cycles after the strobe", addr, waited - 1);
      err_count++;
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
    wb_data_t unused;
    wb_access(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
    wb_access(1'b0, addr, '0, data);
  endtask

  // Random beats with random gaps where valid and data hold until accepted
  task automatic send_beats(input int lane, input int n);
    int gap;
    int waited;
    for (int b = 0; b < n; b++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        push_valid[lane] <= 1'b0;
      end
      @(posedge clk);
      push_valid[lane] <= 1'b1;
      push_data[lane]  <= flow_data_t'($urandom);
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!push_ready[lane] && waited < WAIT_TIMEOUT);
      if (!push_ready[lane]) begin
        $display("Timeout: beat %0d on lane %0d was never accepted", b, lane);
        err_count++;
        break;
      end
    end
    @(posedge clk);
    push_valid[lane] <= 1'b0;
    src_busy[lane] = 1'b0;
  endtask

  task automatic start_source(input int lane, input int n);
    src_busy[lane] = 1'b1;
    fork
      send_beats(lane, n);
    join_none
  endtask

  task automatic wait_source(input int lane);
    int waited;
    waited = 0;
    while (src_busy[lane] && waited < WAIT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (src_busy[lane]) begin
      $display("Timeout: source on lane %0d did not finish", lane);
      err_count++;
    end
  endtask

  // Waits until the model queue holds at least n beats
  task automatic wait_queue(input int n);
    int waited;
    waited = 0;
    while (exp_q.size() < n && waited < WAIT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() < n) begin
      $display("Timeout: model queue never reached %0d beats", n);
      err_count++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || pop_valid) && waited < WAIT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0 || pop_valid) begin
      $display("Timeout: %0d expected beats never left the pop side", exp_q.size());
      err_count++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------

  initial begin
    wb_data_t rd;
    int       lane;
    void'($urandom(SEED));
    rst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    push_valid = '0;
    for (int i = 0; i < NUM_FLOWS; i++) push_data[i] = '0;
    pop_ready = 1'b0;
    pop_hold = 1'b0;
    pop_pct = 100;
    src_busy = '0;
    held_valid = 1'b0;
    beats_checked = 0;
    err_count = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_flag("pop_valid", 1'b0, pop_valid);
    check_flag("wb_ack", 1'b0, wb_ack);
    wb_read(REG_SELECT, rd);
    check_word("REG_SELECT", '0, rd);
    for (int n = 0; n < NUM_FLOWS; n++) begin
      wb_read(wb_addr_t'(REG_COUNT_BASE + n), rd);
      check_word("REG_COUNT", '0, rd);
    end
    end_test("reset values");

    // Select keeps only its low bits and counters ignore writes
    wb_write(REG_SELECT, 32'hFFFF_FFFE);
    wb_read(REG_SELECT, rd);
    check_word("REG_SELECT", 32'hFFFF_FFFE & ((1 << SEL_W) - 1), rd);
    wb_write(wb_addr_t'(REG_COUNT_BASE + 2), 32'h1234_5678);
    wb_read(wb_addr_t'(REG_COUNT_BASE + 2), rd);
    check_word("REG_COUNT", '0, rd);
    for (int a = REG_COUNT_BASE + NUM_FLOWS; a < (1 << WB_ADDR_W); a++) begin
      wb_write(wb_addr_t'(a), 32'hDEAD_BEEF);
      wb_read(wb_addr_t'(a), rd);
      check_word("unmapped word", '0, rd);
    end
    wb_write(REG_SELECT, '0);
    end_test("register access");

    // All lanes hold beats but only the selected one drains
    for (int s = 0; s < NUM_FLOWS; s++) start_source(s, 12);
    for (int s = 0; s < NUM_FLOWS; s++) begin
      wb_write(REG_SELECT, wb_data_t'(s));
      wait_source(s);
    end
    wait_drain();
    end_test("routing");

    pop_pct <= 50;
    for (int s = 0; s < NUM_FLOWS; s++) start_source(s, 16);
    for (int k = 0; k < NUM_FLOWS; k++) begin
      lane = (k * 3 + 1) % NUM_FLOWS;
      wb_write(REG_SELECT, wb_data_t'(lane));
      wait_source(lane);
    end
    wait_drain();
    end_test("back-pressure");

    for (int n = 0; n < NUM_FLOWS; n++) begin
      wb_read(wb_addr_t'(REG_COUNT_BASE + n), rd);
      check_count("REG_COUNT", model_count[n], beat_cnt_t'(rd));
    end
    end_test("counters");

    // Buffer fills from lane 0 and then select moves while stalled
    pop_hold <= 1'b1;
    wb_write(REG_SELECT, '0);
    start_source(0, 3);
    start_source(1, 4);
    wait_queue(2);
    wb_write(REG_SELECT, 32'd1);
    pop_hold <= 1'b0;
    pop_pct <= 70;
    wait_source(1);
    wb_write(REG_SELECT, '0);
    wait_source(0);
    wait_drain();
    end_test("reselect while stalled");

    $display("summary: %0d tests, %0d failed, %0d errors, %0d beats checked",
             tests_run, tests_failed, err_count, beats_checked);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Hard limit on the whole run
  initial begin
    repeat (RUN_LIMIT) @(posedge clk);
    $display("Run limit of %0d cycles reached before the tests finished", RUN_LIMIT);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
